/* bmap_apb_slave.sv */
////////////////////////////////////////////////////////////
// APB3 completer for the bitmap memory: address decode,
// mask register, request issue and read completion
////////////////////////////////////////////////////////////

`include "bmap_params.svh"

module bmap_apb_slave (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [`BMAP_PADDR_WIDTH-1:0] paddr_i,
  input  bmap_pkg::word_t              pwdata_i,
  input  bmap_pkg::word_t              rdata_i,
  output bmap_pkg::word_t              prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  output bmap_pkg::mem_req_t           apb_req_o
);

  import bmap_pkg::*;

  // Memory reads wait two cycles for the arbiter and the core
  typedef enum logic [1:0] {
    s_idle,
    s_wait1,
    s_wait2
  } apb_state_t;

  localparam int unsigned off_width = `BMAP_PADDR_WIDTH - 2;

  apb_state_t             state_r;
  apb_state_t             state_nxt;
  mask_t                  mask_r;
  logic [off_width-1:0]   word_off;
  logic                   access;
  logic                   first_cyc;
  logic                   is_mem;
  logic                   is_mask;
  logic                   is_unmapped;
  logic                   mem_rd;

  // Byte address to word offset
  assign word_off = paddr_i[`BMAP_PADDR_WIDTH-1:2];

  assign is_mem      = word_off < off_width'(`BMAP_DEPTH);
  assign is_mask     = word_off == off_width'(`BMAP_DEPTH);
  assign is_unmapped = ~is_mem & ~is_mask;

  // Access phase of a transfer, and its first cycle
  assign access    = psel_i & penable_i;
  assign first_cyc = access & (state_r == s_idle);
  assign mem_rd    = is_mem & ~pwrite_i;

  // Read FSM, only memory-window reads leave idle
  always_comb begin
    state_nxt = state_r;
    case (state_r)
      s_idle:  if (first_cyc && mem_rd) state_nxt = s_wait1;
      s_wait1: state_nxt = s_wait2;
      s_wait2: state_nxt = s_idle;
      default: state_nxt = s_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      state_r <= s_idle;
      mask_r  <= '0;
    end else begin
      state_r <= state_nxt;
      // The mask register takes writes in the first access cycle
      if (first_cyc && is_mask && pwrite_i) begin
        mask_r <= pwdata_i;
      end
    end
  end

  // One request per memory-window access, carrying the current mask
  always_comb begin
    apb_req_o.valid = first_cyc & is_mem;
    apb_req_o.write = pwrite_i;
    apb_req_o.addr  = word_off[`BMAP_ADDR_WIDTH-1:0];
    apb_req_o.data  = pwdata_i;
    apb_req_o.mask  = mask_r;
  end

  // Everything but a memory read completes at once
  assign pready_o  = access & (mem_rd ? (state_r == s_wait2) : (state_r == s_idle));
  assign pslverr_o = access & is_unmapped;

  // Core data arrives in the third access cycle and goes straight out
  always_comb begin
    prdata_o = '0;
    if (access && !pwrite_i) begin
      if (is_mask) begin
        prdata_o = mask_r;
      end else if (is_mem && state_r == s_wait2) begin
        prdata_o = rdata_i;
      end
    end
  end

endmodule

/* bmap_checker.sv */
////////////////////////////////////////////////////////////
// Testbench checker: reference bitmap model, APB read and
// protocol timing comparisons, error counters
////////////////////////////////////////////////////////////

`include "bmap_params.svh"

module bmap_checker (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic [2:0]                   test_id_i,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [`BMAP_PADDR_WIDTH-1:0] paddr_i,
  input  bmap_pkg::word_t              pwdata_i,
  input  bmap_pkg::word_t              prdata_i,
  input  logic                         pready_i,
  input  logic                         pslverr_i,
  input  logic                         evt_valid_i,
  input  bmap_pkg::bit_idx_t           evt_idx_i,
  input  logic                         evt_set_i,
  input  logic                         evt_ready_i,
  output int                           check_cnt_o,
  output int                           mismatch_cnt_o,
  output int                           proto_cnt_o
);

  import bmap_pkg::*;

  localparam int unsigned off_width = `BMAP_PADDR_WIDTH - 2;

  // Reference copy of the bitmap and of the mask register
  word_t model_mem [`BMAP_DEPTH];
  mask_t model_mask;
  // Expected read data, fixed in the first access cycle
  word_t exp_rdata;
  bit    busy;
  int    acc_cycles;

  logic [off_width-1:0] word_off;
  logic                 access;
  logic                 is_mem;
  logic                 is_mask;

  assign word_off = paddr_i[`BMAP_PADDR_WIDTH-1:2];
  assign is_mem   = word_off < off_width'(`BMAP_DEPTH);
  assign is_mask  = word_off == off_width'(`BMAP_DEPTH);
  assign access   = psel_i & penable_i;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "clear_masked";
      3'd2:    return "mask_register";
      3'd3:    return "event_updates";
      3'd4:    return "ordering";
      default: return "idle";
    endcase
  endfunction

  always @(posedge clk_i) begin : compare
    addr_t                    waddr;
    addr_t                    eaddr;
    logic [bit_pos_width-1:0] bit_pos;
    logic                     first;
    int                       exp_cycles;
    if (!reset_i) begin
      busy       = 1'b0;
      acc_cycles = 0;
      model_mask = '0;
    end else begin
      waddr = word_off[`BMAP_ADDR_WIDTH-1:0];
      first = access & ~busy;
      // Event ready drops only in the first access cycle of a memory access
      check_cnt_o++;
      if (evt_ready_i !== ~(first & is_mem)) begin
        mismatch_cnt_o++;
        $display("Mismatch in %s: evt_ready_o expected %b, actual %b",
                 test_name(test_id_i), ~(first & is_mem), evt_ready_i);
      end
      if (first) begin
        acc_cycles = 1;
        if (is_mem) begin
          exp_rdata = model_mem[waddr];
          // Merge rule, a mask one takes the new bit
          if (pwrite_i) begin
            model_mem[waddr] = (model_mem[waddr] & ~model_mask) | (pwdata_i & model_mask);
          end
        end else if (is_mask) begin
          exp_rdata = model_mask;
          if (pwrite_i) begin
            model_mask = pwdata_i;
          end
        end else begin
          exp_rdata = '0;
        end
      end else if (access) begin
        acc_cycles++;
      end
      if (access && pready_i) begin
        exp_cycles = (is_mem && !pwrite_i) ? 3 : 1;
        check_cnt_o += 2;
        if (acc_cycles != exp_cycles) begin
          proto_cnt_o++;
          $display("Error in %s: access to word offset %0d took %0d cycles instead of %0d",
                   test_name(test_id_i), word_off, acc_cycles, exp_cycles);
        end
        if (pslverr_i !== (~is_mem & ~is_mask)) begin
          mismatch_cnt_o++;
          $display("Mismatch in %s: pslverr at word offset %0d expected %b, actual %b",
                   test_name(test_id_i), word_off, ~is_mem & ~is_mask, pslverr_i);
        end
        if (!pwrite_i) begin
          check_cnt_o++;
          if (prdata_i !== exp_rdata) begin
            mismatch_cnt_o++;
            $display("Mismatch in %s: prdata at word offset %0d expected %h, actual %h",
                     test_name(test_id_i), word_off, exp_rdata, prdata_i);
          end
        end
      end else if (!access && (pready_i || pslverr_i)) begin
        proto_cnt_o++;
        $display("Error in %s: pready or pslverr is high outside an access phase",
                 test_name(test_id_i));
      end
      busy = access & ~pready_i;
      // Each accepted event forces one bit of the model
      if (evt_valid_i && evt_ready_i) begin
        eaddr   = evt_idx_i[$bits(bit_idx_t)-1:bit_pos_width];
        bit_pos = evt_idx_i[bit_pos_width-1:0];
        model_mem[eaddr][bit_pos] = evt_set_i;
      end
    end
  end

endmodule

/* bmap_params.svh */
////////////////////////////////////////////////////////////
// Size macros for the event bitmap memory: word width,
// depth, word address width and APB byte address width
////////////////////////////////////////////////////////////

`ifndef BMAP_PARAMS_SVH
`define BMAP_PARAMS_SVH

// Bits held in one memory word
`define BMAP_DATA_WIDTH 32

// Number of words in the bitmap
`define BMAP_DEPTH 64

// Word address bits, log2 of the depth
`define BMAP_ADDR_WIDTH 6

// APB byte address bits; the word offset drops the two low bits
`define BMAP_PADDR_WIDTH 9

`endif

/* bmap_pkg.sv */
////////////////////////////////////////////////////////////
// Shared types of the bitmap memory: word, mask, address,
// bit index and the memory request struct
////////////////////////////////////////////////////////////

`include "bmap_params.svh"

package bmap_pkg;

  // Bits needed to select one bit inside a word
  localparam int unsigned bit_pos_width = $clog2(`BMAP_DATA_WIDTH);

  // One memory word
  typedef logic [`BMAP_DATA_WIDTH-1:0] word_t;

  // Write mask, a one replaces the bit at that position
  typedef logic [`BMAP_DATA_WIDTH-1:0] mask_t;

  // Word address into the memory
  typedef logic [`BMAP_ADDR_WIDTH-1:0] addr_t;

  // Index of one bit in the whole bitmap
  // Upper bits select the word, lower bits the position within it
  typedef logic [`BMAP_ADDR_WIDTH+bit_pos_width-1:0] bit_idx_t;

  // One memory operation as it moves down the pipeline
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    word_t data;
    mask_t mask;
  } mem_req_t;

endpackage

/* bmap_ram_1r1w.sv */
////////////////////////////////////////////////////////////
// Synchronous RAM, one read port and one write port,
// whole-word writes and a registered read
////////////////////////////////////////////////////////////

`include "bmap_params.svh"

module bmap_ram_1r1w (
  input  logic             clk_i,
  input  logic             w_v_i,
  input  bmap_pkg::addr_t  w_addr_i,
  input  bmap_pkg::word_t  w_data_i,
  input  logic             r_v_i,
  input  bmap_pkg::addr_t  r_addr_i,
  output bmap_pkg::word_t  r_data_o
);

  import bmap_pkg::*;

  word_t mem_r [`BMAP_DEPTH];
  word_t r_data_r;

  always_ff @(posedge clk_i) begin
    if (w_v_i) begin
      mem_r[w_addr_i] <= w_data_i;
    end
    // Read data holds until the next enabled read
    if (r_v_i) begin
      r_data_r <= mem_r[r_addr_i];
    end
  end

  assign r_data_o = r_data_r;

endmodule

/* bmap_req_arb.sv */
////////////////////////////////////////////////////////////
// Request stage: event decode and APB-first arbitration
// into one registered memory request per cycle
////////////////////////////////////////////////////////////

`include "bmap_params.svh"

module bmap_req_arb (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  bmap_pkg::mem_req_t   apb_req_i,
  input  logic                 evt_valid_i,
  input  bmap_pkg::bit_idx_t   evt_idx_i,
  input  logic                 evt_set_i,
  output logic                 evt_ready_o,
  output bmap_pkg::mem_req_t   core_req_o
);

  import bmap_pkg::*;

  mem_req_t evt_req;
  mem_req_t req_nxt;
  mem_req_t core_req_r;
  logic     evt_fire;

  // Events stall only while APB owns the slot
  assign evt_ready_o = ~apb_req_i.valid;
  assign evt_fire    = evt_valid_i & evt_ready_o;

  // A single-bit update becomes a word write with a one-hot mask
  always_comb begin
    evt_req.valid = evt_fire;
    evt_req.write = 1'b1;
    evt_req.addr  = evt_idx_i[$bits(bit_idx_t)-1:bit_pos_width];
    evt_req.data  = {`BMAP_DATA_WIDTH{evt_set_i}};
    evt_req.mask  = mask_t'(1) << evt_idx_i[bit_pos_width-1:0];
  end

  // APB wins the slot when both want it
  always_comb begin
    if (apb_req_i.valid) begin
      req_nxt = apb_req_i;
    end else begin
      req_nxt = evt_req;
    end
  end

  // Payload bits keep their last value through reset
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      core_req_r.valid <= 1'b0;
    end else begin
      core_req_r <= req_nxt;
    end
  end

  assign core_req_o = core_req_r;

endmodule

/* bmap_rmw_core.sv */
////////////////////////////////////////////////////////////
// Masked-write core over a 1R1W RAM: read, merge and write
// pipeline with same-address hazard forwarding
////////////////////////////////////////////////////////////

module bmap_rmw_core (
  input  logic                clk_i,
  input  logic                reset_i,
  input  bmap_pkg::mem_req_t  req_i,
  output bmap_pkg::word_t     rdata_o
);

  import bmap_pkg::*;

  // Request held for the merge cycle
  addr_t addr_r;
  word_t wr_data_r;
  mask_t wr_mask_r;

  // Pending write and forwarding state
  logic  wr_pend_r;
  logic  haz_r;
  word_t buf_r;

  word_t ram_rdata;
  word_t merge_base;
  word_t merge_data;
  logic  addr_match;
  logic  haz;
  logic  ram_rd_en;
  logic  ram_wr_en;

  // The incoming request hits the word that is about to be written
  assign addr_match = wr_pend_r & req_i.valid & (addr_r == req_i.addr);
  assign haz        = addr_match;

  // The RAM copy is stale on a hazard, so the read is skipped
  assign ram_rd_en = req_i.valid & ~haz;

  // A write followed by a write to the same word is not committed
  // Its merged value lives on in the buffer instead
  assign ram_wr_en = wr_pend_r & ~(addr_match & req_i.write);

  // Old word from the buffer after a hazard, else from the RAM
  assign merge_base = haz_r ? buf_r : ram_rdata;
  assign merge_data = (merge_base & ~wr_mask_r) | (wr_data_r & wr_mask_r);

  bmap_ram_1r1w i_ram (
    .clk_i    (clk_i),
    .w_v_i    (ram_wr_en),
    .w_addr_i (addr_r),
    .w_data_i (merge_data),
    .r_v_i    (ram_rd_en),
    .r_addr_i (req_i.addr),
    .r_data_o (ram_rdata)
  );

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      wr_pend_r <= 1'b0;
      haz_r     <= 1'b0;
    end else begin
      wr_pend_r <= req_i.valid & req_i.write;
      haz_r     <= haz;
    end
  end

  // Address for every request, data and mask only for writes
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      addr_r <= req_i.addr;
      if (req_i.write) begin
        wr_data_r <= req_i.data;
        wr_mask_r <= req_i.mask;
      end
    end
    // Keep the newest merged word for the next hazard
    if (wr_pend_r) begin
      buf_r <= merge_data;
    end
  end

  // A read right after a same-word write sees the merged word
  assign rdata_o = haz_r ? buf_r : ram_rdata;

endmodule

/* bmap_top.sv */
////////////////////////////////////////////////////////////
// Top level of the bitmap memory: APB front end,
// request arbiter and read-modify-write core
////////////////////////////////////////////////////////////

`include "bmap_params.svh"

module bmap_top (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [`BMAP_PADDR_WIDTH-1:0] paddr_i,
  input  bmap_pkg::word_t              pwdata_i,
  output bmap_pkg::word_t              prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  input  logic                         evt_valid_i,
  input  bmap_pkg::bit_idx_t           evt_idx_i,
  input  logic                         evt_set_i,
  output logic                         evt_ready_o
);

  import bmap_pkg::*;

  // Front end to arbiter, arbiter to core, core back to front end
  mem_req_t apb_req;
  mem_req_t core_req;
  word_t    rdata;

  bmap_apb_slave i_apb_slave (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .rdata_i   (rdata),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .apb_req_o (apb_req)
  );

  bmap_req_arb i_req_arb (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .apb_req_i   (apb_req),
    .evt_valid_i (evt_valid_i),
    .evt_idx_i   (evt_idx_i),
    .evt_set_i   (evt_set_i),
    .evt_ready_o (evt_ready_o),
    .core_req_o  (core_req)
  );

  bmap_rmw_core i_rmw_core (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (core_req),
    .rdata_o (rdata)
  );

endmodule

/* flist.f */
+incdir+.
bmap_pkg.sv
bmap_ram_1r1w.sv
bmap_rmw_core.sv
bmap_req_arb.sv
bmap_apb_slave.sv
bmap_top.sv
bmap_checker.sv
tb_bmap.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the bitmap memory testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator was not found on the PATH"
  exit 1
fi

if ! verilator --binary --timing --top-module tb_bmap -f flist.f -o sim_bmap; then
  echo "Verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/sim_bmap 2>&1)"
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if grep -q "Simulation completed successfully" <<< "$sim_out"; then
  exit 0
fi
exit 1

/* tb_bmap.sv */
////////////////////////////////////////////////////////////
// Testbench top for the bitmap memory: clock, reset, APB
// and event stimulus, DUT, checker and watchdog
////////////////////////////////////////////////////////////

`include "bmap_params.svh"

module tb_bmap;

  import bmap_pkg::*;

  typedef logic [`BMAP_PADDR_WIDTH-1:0] paddr_t;

  localparam int clk_period     = 8;
  localparam int reset_cycles   = 16;
  localparam int off_w          = `BMAP_PADDR_WIDTH - 2;
  localparam int n_words        = `BMAP_DEPTH;
  localparam int n_rand_wr      = 48;
  localparam int n_unmapped     = 8;
  localparam int n_evt_cycles   = 600;
  localparam int n_order_rounds = 60;
  // APB transfers and event cycles of all four tests
  localparam int planned_ops = (1 + 2 * n_words + 3 * n_rand_wr) + (3 + 3 * n_unmapped)
                             + (n_evt_cycles + n_words) + (3 * n_order_rounds + n_words);
  // A memory read needs five cycles with setup and the idle gap
  localparam int op_cycles      = 8;
  localparam int timeout_cycles = planned_ops * op_cycles + reset_cycles;
  localparam paddr_t mask_paddr = paddr_t'(n_words * 4);

  logic     clk_i;
  logic     reset_i;
  logic     psel;
  logic     penable;
  logic     pwrite;
  paddr_t   paddr;
  word_t    pwdata;
  word_t    prdata;
  logic     pready;
  logic     pslverr;
  logic     evt_valid;
  bit_idx_t evt_idx;
  logic     evt_set;
  logic     evt_ready;
  logic     evt_en;
  logic [2:0] test_id;
  addr_t    hot_word;
  integer   seed;
  int       check_cnt;
  int       mismatch_cnt;
  int       proto_cnt;

  bmap_top i_bmap_top (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .paddr_i     (paddr),
    .pwdata_i    (pwdata),
    .prdata_o    (prdata),
    .pready_o    (pready),
    .pslverr_o   (pslverr),
    .evt_valid_i (evt_valid),
    .evt_idx_i   (evt_idx),
    .evt_set_i   (evt_set),
    .evt_ready_o (evt_ready)
  );

  bmap_checker i_bmap_checker (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .test_id_i      (test_id),
    .psel_i         (psel),
    .penable_i      (penable),
    .pwrite_i       (pwrite),
    .paddr_i        (paddr),
    .pwdata_i       (pwdata),
    .prdata_i       (prdata),
    .pready_i       (pready),
    .pslverr_i      (pslverr),
    .evt_valid_i    (evt_valid),
    .evt_idx_i      (evt_idx),
    .evt_set_i      (evt_set),
    .evt_ready_i    (evt_ready),
    .check_cnt_o    (check_cnt),
    .mismatch_cnt_o (mismatch_cnt),
    .proto_cnt_o    (proto_cnt)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  function automatic paddr_t word_paddr(input int off);
    return {off_w'(off), 2'b00};
  endfunction

  // Random word offset in the unmapped range above the mask register
  function automatic paddr_t unmapped_paddr();
    return word_paddr(n_words + 1 + int'($unsigned($random(seed)) % 63));
  endfunction

  // Single APB transfer, setup then access until pready
  task automatic apb_transfer(input logic write, input paddr_t addr, input word_t wdata);
    @(posedge clk_i);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk_i);
    penable <= 1'b1;
    @(posedge clk_i);
    while (!pready) begin
      @(posedge clk_i);
    end
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // Most events hit a hot word that moves now and then, giving same-word runs
  initial begin : event_source
    logic [bit_pos_width-1:0] bit_pos;
    hot_word = '0;
    evt_valid <= 1'b0;
    evt_idx   <= '0;
    evt_set   <= 1'b0;
    forever begin
      @(posedge clk_i);
      // A pending event stays on the port until it is taken
      if (!evt_valid || evt_ready) begin
        if (evt_en && ($unsigned($random(seed)) % 4) != 0) begin
          if (($unsigned($random(seed)) % 16) == 0) begin
            hot_word = addr_t'($unsigned($random(seed)));
          end
          bit_pos = bit_pos_width'($unsigned($random(seed)));
          if (($unsigned($random(seed)) % 4) == 0) begin
            evt_idx <= {addr_t'($unsigned($random(seed))), bit_pos};
          end else begin
            evt_idx <= {hot_word, bit_pos};
          end
          evt_set   <= 1'($random(seed));
          evt_valid <= 1'b1;
        end else begin
          evt_valid <= 1'b0;
        end
      end
    end
  end

  initial begin : main_seq
    addr_t  waddr;
    paddr_t upaddr;
    seed     = 32'h3776;
    reset_i <= 1'b0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    evt_en  <= 1'b0;
    test_id <= 3'd0;
    repeat (reset_cycles) @(posedge clk_i);
    reset_i <= 1'b1;

    // Clear everything under a full mask, then random masked writes
    test_id <= 3'd1;
    apb_transfer(1'b1, mask_paddr, '1);
    for (int i = 0; i < n_words; i++) begin
      apb_transfer(1'b1, word_paddr(i), '0);
    end
    for (int i = 0; i < n_words; i++) begin
      apb_transfer(1'b0, word_paddr(i), '0);
    end
    for (int i = 0; i < n_rand_wr; i++) begin
      waddr = addr_t'($unsigned($random(seed)));
      apb_transfer(1'b1, mask_paddr, word_t'($random(seed)));
      apb_transfer(1'b1, word_paddr(int'(waddr)), word_t'($random(seed)));
      apb_transfer(1'b0, word_paddr(int'(waddr)), '0);
    end

    // Mask readback and unmapped accesses that must change nothing
    test_id <= 3'd2;
    apb_transfer(1'b1, mask_paddr, word_t'($random(seed)));
    apb_transfer(1'b0, mask_paddr, '0);
    for (int i = 0; i < n_unmapped; i++) begin
      upaddr = unmapped_paddr();
      apb_transfer(1'b1, upaddr, word_t'($random(seed)));
      apb_transfer(1'b0, unmapped_paddr(), '0);
      // The memory word sharing the low offset bits keeps its value
      apb_transfer(1'b0, word_paddr(int'(upaddr[`BMAP_PADDR_WIDTH-1:2]) - n_words), '0);
    end
    apb_transfer(1'b0, mask_paddr, '0);

    // Event stream alone, then a full readback
    test_id <= 3'd3;
    evt_en  <= 1'b1;
    repeat (n_evt_cycles) @(posedge clk_i);
    evt_en  <= 1'b0;
    for (int i = 0; i < n_words; i++) begin
      apb_transfer(1'b0, word_paddr(i), '0);
    end

    // APB reads and writes racing the event stream
    test_id <= 3'd4;
    evt_en  <= 1'b1;
    for (int i = 0; i < n_order_rounds; i++) begin
      apb_transfer(1'b0, word_paddr(int'(hot_word)), '0);
      apb_transfer(1'b1, word_paddr(int'(hot_word)), word_t'($random(seed)));
      apb_transfer(1'b0, word_paddr(int'(addr_t'($unsigned($random(seed))))), '0);
    end
    evt_en  <= 1'b0;
    for (int i = 0; i < n_words; i++) begin
      apb_transfer(1'b0, word_paddr(i), '0);
    end

    repeat (4) @(posedge clk_i);
    $display("Checks: %0d, mismatches: %0d, protocol errors: %0d",
             check_cnt, mismatch_cnt, proto_cnt);
    if (mismatch_cnt == 0 && proto_cnt == 0 && check_cnt > 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (timeout_cycles) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule
